//--- motor_pkg.sv
// shared definitions for the four-axis motor core
// address map, safety constants and the register bus word types
// import with motor_pkg::* in each module header

package motor_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------
    localparam int NUM_AXES = 4;           // motor axes on the board
    localparam int CUR_W    = 16;          // dac command / adc feedback
    localparam int ADDR_W   = 16;          // register address
    localparam int DATA_W   = 32;          // register data

    // ------------------------------------------------------------------
    // address map
    //   addr[15:12] block, addr[7:4] channel, addr[3:0] offset
    // ------------------------------------------------------------------
    localparam logic [3:0] ADDR_MAIN    = 4'd0;   // other blocks read zero
    localparam logic [3:0] CHAN_BOARD   = 4'd0;   // axes sit on channels 1..4
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;   // axis feedback readback
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;   // axis current command
    localparam logic [3:0] OFF_STATUS   = 4'd0;   // board status/control

    // safety check
    localparam logic [CUR_W-1:0] SAFETY_MARGIN = 16'h0100;  // added to 2*cmd
    localparam int SAFETY_HOLD = 4;        // consecutive over samples to trip
    localparam int HOLD_CNT_W  = $clog2(SAFETY_HOLD + 1);

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------

    // register address split
    typedef struct packed {
        logic [3:0]          block;        // main / other spaces
        logic [ADDR_W-13:0]  unused;       // bits [11:8], not decoded
        logic [3:0]          channel;      // 0 board, 1..4 axis
        logic [3:0]          offset;       // register within channel
    } reg_addr_t;

    // write word as seen by the board status register
    typedef struct packed {
        logic                        clear_fault;      // msb, one-shot
        logic [DATA_W-NUM_AXES-2:0]  reserved;
        logic [NUM_AXES-1:0]         amp_enable_mask;  // lsbs
    } status_wr_t;

    // write word as seen by an axis command register
    typedef struct packed {
        logic [DATA_W-CUR_W-1:0]  reserved;
        logic [CUR_W-1:0]         value;   // new current command
    } dac_wr_t;

    // one bus word, decoded per target
    typedef union packed {
        status_wr_t  status;
        dac_wr_t     dac;
    } reg_word_u;

    // decoded write, at most one strobe set
    typedef struct packed {
        logic [NUM_AXES-1:0]  dac_we;      // one per axis
        logic                 status_we;   // channel 0 status write
        reg_word_u            word;
    } wr_req_t;

    // one current value per axis, axis 0 in the lsbs
    typedef logic [NUM_AXES-1:0][CUR_W-1:0] axis_cur_t;

endpackage

//--- reg_decoder.sv
// register bus write decode
// samples the write port, then turns the address into one target strobe

`timescale 1ns/1ps

module reg_decoder import motor_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  logic       reg_wen,     // one write per cycle, no back-pressure
    input  reg_addr_t  reg_waddr,
    input  reg_word_u  reg_wdata,
    output wr_req_t    wr_req       // registered, to command and board regs
);

    // ------------------------------------------------------------------
    // stage 1: capture the write port
    // ------------------------------------------------------------------
    logic       wen_q;
    reg_addr_t  waddr_q;
    reg_word_u  wdata_q;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            wen_q <= 1'b0;
        end else begin
            wen_q <= reg_wen;
        end
        waddr_q <= reg_waddr;      // payload only
        wdata_q <= reg_wdata;
    end

    // ------------------------------------------------------------------
    // address compare
    // ------------------------------------------------------------------
    logic                 main_hit;    // write lands in the main space
    logic                 status_hit;
    logic [NUM_AXES-1:0]  dac_hit;

    assign main_hit   = wen_q && (waddr_q.block == ADDR_MAIN);
    assign status_hit = main_hit && (waddr_q.channel == CHAN_BOARD)
                                 && (waddr_q.offset == OFF_STATUS);

    // axis a lives on channel a+1
    always_comb begin
        dac_hit = '0;
        for (int a = 0; a < NUM_AXES; a++) begin
            dac_hit[a] = main_hit && (waddr_q.channel == 4'(a + 1))
                                  && (waddr_q.offset == OFF_DAC_CTRL);
        end
    end

    // ------------------------------------------------------------------
    // stage 2: registered request
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            wr_req.dac_we    <= '0;
            wr_req.status_we <= 1'b0;
        end else begin
            wr_req.dac_we    <= dac_hit;
            wr_req.status_we <= status_hit;
        end
        wr_req.word <= wdata_q;    // decoded by whichever target fires
    end

    // at most one target per write, whatever the address
    a_one_target : assert property (@(posedge sysclk) disable iff (rst)
        $onehot0({wr_req.dac_we, wr_req.status_we}));

endmodule

//--- dac_cmd_regs.sv
// per-axis current command registers
// loaded from decoded bus writes, outputs feed the amplifiers directly

`timescale 1ns/1ps

module dac_cmd_regs import motor_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  wr_req_t    wr_req,      // from reg_decoder
    output axis_cur_t  cur_cmd      // to safety check, readback and pins
);

    // value field of the write word, shared by all axes
    logic [CUR_W-1:0] wr_value;

    assign wr_value = wr_req.word.dac.value;

    // ------------------------------------------------------------------
    // one command register per axis
    // ------------------------------------------------------------------
    for (genvar g = 0; g < NUM_AXES; g++) begin : g_axis

        // commands start at zero so the amps see no current out of reset
        always_ff @(posedge sysclk) begin
            if (rst) begin
                cur_cmd[g] <= '0;
            end else if (wr_req.dac_we[g]) begin   // strobe for this axis
                cur_cmd[g] <= wr_value;
            end
        end

    end

endmodule

//--- safety_check.sv
// per-axis over-current check
// trips a sticky fault when feedback stays above 2*command + margin
// fault holds until the board register sends clear_fault

`timescale 1ns/1ps

module safety_check import motor_pkg::*; (
    input  logic                 sysclk,
    input  logic                 rst,
    input  axis_cur_t            cur_fb,       // adc feedback, every cycle
    input  axis_cur_t            cur_cmd,      // dac command registers
    input  logic                 clear_fault,  // one-cycle pulse from board_regs
    output logic [NUM_AXES-1:0]  fault         // latched, one per axis
);

    // ------------------------------------------------------------------
    // sample stage
    // ------------------------------------------------------------------
    axis_cur_t fb_q;
    axis_cur_t cmd_q;

    always_ff @(posedge sysclk) begin
        fb_q  <= cur_fb;           // new sample each cycle
        cmd_q <= cur_cmd;
    end

    // ------------------------------------------------------------------
    // compare stage
    //   unsigned, widened to 18 bits so 2*cmd + margin cannot wrap
    // ------------------------------------------------------------------
    logic [NUM_AXES-1:0]  over;        // comb compare
    logic [NUM_AXES-1:0]  over_q;      // registered compare

    always_comb begin
        for (int a = 0; a < NUM_AXES; a++) begin
            over[a] = 18'(fb_q[a]) > ((18'(cmd_q[a]) << 1) + 18'(SAFETY_MARGIN));
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            over_q <= '0;
        end else begin
            over_q <= over;
        end
    end

    // ------------------------------------------------------------------
    // persistence count and fault latch
    // ------------------------------------------------------------------
    logic [NUM_AXES-1:0][HOLD_CNT_W-1:0] hold_cnt;   // consecutive over samples

    for (genvar g = 0; g < NUM_AXES; g++) begin : g_axis

        always_ff @(posedge sysclk) begin
            if (rst) begin
                hold_cnt[g] <= '0;
                fault[g]    <= 1'b0;
            end else begin
                // any good sample restarts the count, saturate at the limit
                if (!over_q[g]) begin
                    hold_cnt[g] <= '0;
                end else if (hold_cnt[g] != HOLD_CNT_W'(SAFETY_HOLD)) begin
                    hold_cnt[g] <= hold_cnt[g] + 1'b1;
                end

                if (clear_fault) begin
                    fault[g] <= 1'b0;          // re-trips if still over
                end else if (hold_cnt[g] == HOLD_CNT_W'(SAFETY_HOLD)) begin
                    fault[g] <= 1'b1;          // sticky
                end
            end
        end

    end

    // a fault only drops after a clear pulse from the board register
    a_fault_sticky : assert property (@(posedge sysclk) disable iff (rst)
        |($past(fault) & ~fault) |-> $past(clear_fault));

endmodule

//--- board_regs.sv
// channel 0 board registers and the register read mux
// holds the amp enable mask, pulses clear_fault, builds the status word

`timescale 1ns/1ps

module board_regs import motor_pkg::*; (
    input  logic                 sysclk,
    input  logic                 rst,
    input  wr_req_t              wr_req,       // decoded writes
    input  logic [NUM_AXES-1:0]  fault,        // latched safety faults
    input  axis_cur_t            cur_cmd,      // command readback
    input  axis_cur_t            cur_fb,       // feedback readback
    input  logic [3:0]           board_id,     // rotary switch
    input  reg_addr_t            reg_raddr,
    output logic                 clear_fault,  // one-cycle pulse
    output logic [NUM_AXES-1:0]  amp_enable,
    output logic [DATA_W-1:0]    reg_rdata     // 1 cycle after reg_raddr
);

    // ------------------------------------------------------------------
    // status/control register
    // ------------------------------------------------------------------
    logic [NUM_AXES-1:0] mask;         // software amp enable request

    always_ff @(posedge sysclk) begin
        if (rst) begin
            mask        <= '0;         // amps stay off until written
            clear_fault <= 1'b0;
        end else begin
            if (wr_req.status_we) begin
                mask <= wr_req.word.status.amp_enable_mask;
            end
            clear_fault <= wr_req.status_we && wr_req.word.status.clear_fault;
        end
    end

    // faulted axes are dropped regardless of the mask
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_enable <= '0;
        end else begin
            amp_enable <= mask & ~fault;
        end
    end

    // ------------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------------
    logic [DATA_W-1:0] status_word;
    logic [DATA_W-1:0] rd_next;

    // [27:24] id, [11:8] amp enable, [7:4] fault, [3:0] mask
    assign status_word = {4'h0, board_id, 12'h000, amp_enable, fault, mask};

    always_comb begin
        rd_next = '0;                              // unmapped reads as zero
        if (reg_raddr.block == ADDR_MAIN) begin
            if (reg_raddr.channel == CHAN_BOARD) begin
                if (reg_raddr.offset == OFF_STATUS) begin
                    rd_next = status_word;
                end
            end else begin
                for (int a = 0; a < NUM_AXES; a++) begin
                    if (reg_raddr.channel == 4'(a + 1)) begin   // axis a
                        if (reg_raddr.offset == OFF_ADC_DATA) begin
                            rd_next = DATA_W'(cur_fb[a]);
                        end else if (reg_raddr.offset == OFF_DAC_CTRL) begin
                            rd_next = DATA_W'(cur_cmd[a]);
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

//--- motor_axis_top.sv
// four-axis motor core top level
// register bus in, current commands and amp enables out

`timescale 1ns/1ps

module motor_axis_top import motor_pkg::*; (
    input  logic                 sysclk,
    input  logic                 rst,
    // register write port
    input  logic                 reg_wen,
    input  reg_addr_t            reg_waddr,
    input  reg_word_u            reg_wdata,
    // register read port, 1 cycle latency
    input  reg_addr_t            reg_raddr,
    output logic [DATA_W-1:0]    reg_rdata,
    // board side
    input  axis_cur_t            cur_fb,       // parallel adc feedback
    input  logic [3:0]           board_id,
    output axis_cur_t            cur_cmd,      // parallel dac commands
    output logic [NUM_AXES-1:0]  amp_enable
);

    // ------------------------------------------------------------------
    // local wires
    // ------------------------------------------------------------------
    wr_req_t              wr_req;          // decoded write
    logic [NUM_AXES-1:0]  fault;           // safety latches
    logic                 clear_fault;     // board reg -> safety

    reg_decoder decode_i (
        .sysclk    (sysclk),
        .rst       (rst),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .wr_req    (wr_req)
    );

    dac_cmd_regs dac_i (
        .sysclk  (sysclk),
        .rst     (rst),
        .wr_req  (wr_req),
        .cur_cmd (cur_cmd)
    );

    // fb vs 2*cmd check per axis
    safety_check safe_i (
        .sysclk      (sysclk),
        .rst         (rst),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .clear_fault (clear_fault),
        .fault       (fault)
    );

    // channel 0 and readback
    board_regs chan0_i (
        .sysclk      (sysclk),
        .rst         (rst),
        .wr_req      (wr_req),
        .fault       (fault),
        .cur_cmd     (cur_cmd),
        .cur_fb      (cur_fb),
        .board_id    (board_id),
        .reg_raddr   (reg_raddr),
        .clear_fault (clear_fault),
        .amp_enable  (amp_enable),
        .reg_rdata   (reg_rdata)
    );

endmodule

//--- tb_motor_axis_top.sv
// self-checking testbench for the four-axis motor core
// keeps a model of mask, commands, feedback and faults, checks reads and pins

`timescale 1ns/1ps

module tb_motor_axis_top import motor_pkg::*; ();

    logic                 sysclk;
    logic                 rst;
    logic                 reg_wen;
    reg_addr_t            reg_waddr;
    reg_word_u            reg_wdata;
    reg_addr_t            reg_raddr;
    logic [DATA_W-1:0]    reg_rdata;
    axis_cur_t            cur_fb;
    logic [3:0]           board_id;
    axis_cur_t            cur_cmd;
    logic [NUM_AXES-1:0]  amp_enable;

    // reference model state
    logic [CUR_W-1:0]     m_cmd [NUM_AXES];
    logic [CUR_W-1:0]     m_fb  [NUM_AXES];
    logic [NUM_AXES-1:0]  m_mask;
    logic [NUM_AXES-1:0]  m_fault;

    int errors;                        // pin and timeout failures
    int rd_errors;                     // readback mismatches

    // read request handed to the compare process
    logic               rd_pend;
    logic [DATA_W-1:0]  rd_exp;
    logic [ADDR_W-1:0]  rd_addr;
    logic               cmp_valid;
    logic [DATA_W-1:0]  cmp_exp;
    logic [ADDR_W-1:0]  cmp_addr;

    motor_axis_top dut_i (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;  // 40 ns period
    end

    // ------------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------------
    function automatic logic [ADDR_W-1:0] make_addr(input logic [3:0] blk,
            input logic [3:0] ch, input logic [3:0] off);
        return {blk, 4'h0, ch, off};
    endfunction

    // feedback above 2*cmd + margin, no wrap
    function automatic logic is_over(input logic [CUR_W-1:0] fb,
            input logic [CUR_W-1:0] cmd);
        logic [17:0] lim;
        lim = {2'b00, cmd} + {2'b00, cmd} + {2'b00, SAFETY_MARGIN};
        return {2'b00, fb} > lim;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        int idx;
        word = '0;
        idx  = int'(addr[7:4]) - 1;    // axis a on channel a+1
        if (addr[15:12] == ADDR_MAIN) begin
            if (addr[7:4] == CHAN_BOARD && addr[3:0] == OFF_STATUS) begin
                word[3:0]   = m_mask;
                word[7:4]   = m_fault;
                word[11:8]  = m_mask & ~m_fault;
                word[27:24] = board_id;
            end else if (idx >= 0 && idx < NUM_AXES) begin
                if (addr[3:0] == OFF_ADC_DATA) begin
                    word[15:0] = m_fb[idx];
                end else if (addr[3:0] == OFF_DAC_CTRL) begin
                    word[15:0] = m_cmd[idx];
                end
            end
        end
        return word;
    endfunction

    // ------------------------------------------------------------------
    // compare process, rdata checked one edge after the address
    // ------------------------------------------------------------------
    always @(posedge sysclk) begin
        cmp_valid <= rd_pend;
        cmp_exp   <= rd_exp;
        cmp_addr  <= rd_addr;
    end

    always @(negedge sysclk) begin
        if (cmp_valid == 1'b1) begin
            if (reg_rdata !== cmp_exp) begin
                rd_errors++;
                $display("Error: reg_rdata at address %h is %h, expected %h",
                         cmp_addr, reg_rdata, cmp_exp);
            end
        end
    end

    // ------------------------------------------------------------------
    // bus and pin tasks
    // ------------------------------------------------------------------
    task automatic settle(input int n);
        for (int i = 0; i < n; i++) @(negedge sysclk);
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr);
        @(negedge sysclk);
        reg_raddr = addr;
        rd_addr   = addr;
        rd_exp    = expected_read(addr);
        rd_pend   = 1'b1;
        @(negedge sysclk);
        rd_pend   = 1'b0;              // compared on this edge
    endtask

    // one write, model follows the address map
    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int idx;
        idx = int'(addr[7:4]) - 1;
        @(negedge sysclk);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        @(negedge sysclk);
        reg_wen   = 1'b0;
        if (addr[15:12] == ADDR_MAIN) begin
            if (addr[7:4] == CHAN_BOARD && addr[3:0] == OFF_STATUS) begin
                m_mask = data[3:0];
                if (data[31]) m_fault = '0;          // clear pulse
            end else if (idx >= 0 && idx < NUM_AXES && addr[3:0] == OFF_DAC_CTRL) begin
                m_cmd[idx] = data[15:0];
            end
        end
        settle(4);                     // enable reaches the pin at N+3
    endtask

    task automatic set_fb(input int a, input logic [CUR_W-1:0] v);
        @(negedge sysclk);
        cur_fb[a] = v;
        m_fb[a]   = v;
    endtask

    task automatic check_outputs();
        @(negedge sysclk);
        for (int a = 0; a < NUM_AXES; a++) begin
            if (cur_cmd[a] !== m_cmd[a]) begin
                errors++;
                $display("Error: cur_cmd[%0d] is %h, expected %h", a, cur_cmd[a], m_cmd[a]);
            end
        end
        if (amp_enable !== (m_mask & ~m_fault)) begin
            errors++;
            $display("Error: amp_enable is %h, expected %h", amp_enable, m_mask & ~m_fault);
        end
    endtask

    // fault set or clear shows up on amp_enable after a few cycles
    task automatic wait_amp(input int limit);
        int n;
        logic [NUM_AXES-1:0] exp_amp;
        n = 0;
        exp_amp = m_mask & ~m_fault;
        while (amp_enable !== exp_amp && n < limit) begin
            @(negedge sysclk);
            n++;
        end
        if (amp_enable !== exp_amp) begin
            errors++;
            $display("timeout: amp_enable never reached the expected value in %0d cycles", limit);
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0]       rnd;
        logic [CUR_W-1:0]  v;
        logic [CUR_W-1:0]  hi;
        rnd       = $urandom(32'hf9b1_0606);   // single seed for the run
        errors    = 0;
        rd_errors = 0;
        rd_pend   = 1'b0;
        rd_exp    = '0;
        rd_addr   = '0;
        rst       = 1'b1;
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        cur_fb    = '0;
        rnd       = $urandom;
        board_id  = rnd[3:0];
        m_mask    = '0;
        m_fault   = '0;
        for (int a = 0; a < NUM_AXES; a++) begin
            m_cmd[a] = '0;
            m_fb[a]  = '0;
        end
        for (int i = 0; i < 10; i++) @(posedge sysclk);
        @(negedge sysclk);
        rst = 1'b0;

        // reset values, board id
        check_outputs();
        read_check(make_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS));

        // random commands, then writes that must be ignored
        for (int a = 0; a < NUM_AXES; a++) begin
            rnd = $urandom;
            write_reg(make_addr(ADDR_MAIN, 4'(a + 1), OFF_DAC_CTRL), rnd);
        end
        write_reg(make_addr(4'h1, 4'h1, OFF_DAC_CTRL), 32'h0000_1234);   // other block
        write_reg(make_addr(ADDR_MAIN, 4'h2, 4'h5), 32'h0000_5678);      // bad offset
        write_reg(make_addr(ADDR_MAIN, CHAN_BOARD, 4'h3), 32'h0000_000f);
        write_reg(make_addr(ADDR_MAIN, 4'h6, OFF_DAC_CTRL), 32'h0000_9abc); // no axis
        check_outputs();
        for (int a = 0; a < NUM_AXES; a++) begin
            read_check(make_addr(ADDR_MAIN, 4'(a + 1), OFF_DAC_CTRL));
        end
        read_check(make_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS));
        read_check(make_addr(4'h1, 4'h1, OFF_DAC_CTRL));
        read_check(make_addr(ADDR_MAIN, 4'h2, 4'h5));

        // held feedback, kept below the trip level
        for (int a = 0; a < NUM_AXES; a++) begin
            rnd = $urandom;
            v   = rnd[15:0];
            while (is_over(v, m_cmd[a])) v = v >> 1;
            set_fb(a, v);
        end
        settle(2);
        for (int a = 0; a < NUM_AXES; a++) begin
            read_check(make_addr(ADDR_MAIN, 4'(a + 1), OFF_ADC_DATA));
        end

        // enable mask, axis 2 always on
        rnd = $urandom;
        write_reg(make_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS), {28'h0, rnd[3:0] | 4'h4});
        check_outputs();
        read_check(make_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS));

        // ------------------------------------------------------------------
        // over-current on axis 2
        // ------------------------------------------------------------------
        set_fb(2, 16'h0000);
        rnd = $urandom;
        write_reg(make_addr(ADDR_MAIN, 4'h3, OFF_DAC_CTRL), {18'h0, rnd[13:0]});
        hi = m_cmd[2] + m_cmd[2] + SAFETY_MARGIN + 16'd1 + {8'h00, rnd[21:14]};

        // one-cycle spike must not trip
        @(negedge sysclk);
        cur_fb[2] = hi;
        @(negedge sysclk);
        cur_fb[2] = m_fb[2];
        settle(12);
        check_outputs();
        read_check(make_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS));

        // held spike trips axis 2 only
        set_fb(2, hi);
        m_fault[2] = 1'b1;
        wait_amp(40);
        settle(2);
        check_outputs();
        read_check(make_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS));
        read_check(make_addr(ADDR_MAIN, 4'h3, OFF_ADC_DATA));

        // lower feedback, then clear
        set_fb(2, 16'h0000);
        settle(4);
        write_reg(make_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS), {1'b1, 27'h0, m_mask});
        wait_amp(20);
        check_outputs();
        read_check(make_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS));

        settle(2);
        $display("errors: %0d pin/timeout, %0d readback", errors, rd_errors);
        if (errors == 0 && rd_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- motor_axis.f
motor_pkg.sv
reg_decoder.sv
dac_cmd_regs.sv
safety_check.sv
board_regs.sv
motor_axis_top.sv
tb_motor_axis_top.sv

//--- run_sim.sh
#!/bin/bash
# build and run the motor axis testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --assert --top-module tb_motor_axis_top -f motor_axis.f -o sim_motor_axis
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_motor_axis)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
